//--- logic/conv_ctrl_pkg.sv
// Shared widths and FSM encodings; the widths limit the configuration to kernels under 16 taps and 255 channels
`default_nettype none

package conv_ctrl_pkg;

    // ========================================
    // Configuration field widths
    // ========================================
    localparam int LAYER_ID_W = 4;
    localparam int KSIZE_W    = 4;
    localparam int STRIDE_W   = 2;
    localparam int PAD_W      = 3;
    localparam int COUNT_W    = 8;

    // Entries in the scheduler configuration ROM
    localparam int ROM_DEPTH  = 8;

    typedef logic [LAYER_ID_W-1:0] layer_id_t;
    typedef logic [KSIZE_W-1:0]    ksize_t;
    typedef logic [STRIDE_W-1:0]   stride_t;
    typedef logic [PAD_W-1:0]      pad_t;
    // Channels, filters and temporal length
    typedef logic [COUNT_W-1:0]    count_t;

    // ========================================
    // State machines
    // ========================================
    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_WAIT_DATA, SEQ_RUN, SEQ_NEXT, SEQ_FINISHED
    } seq_state_t;

    typedef enum logic [2:0] {
        SCH_IDLE, SCH_START, SCH_RUN, SCH_WAIT_READ, SCH_COMPLETE
    } sched_state_t;

    typedef enum logic [2:0] {
        ADR_IDLE, ADR_WEIGHT_REQ, ADR_TAP, ADR_WAIT_RESULT,
        ADR_WRITE, ADR_NEXT_FILTER, ADR_DONE
    } addr_state_t;

endpackage

`default_nettype wire

//--- logic/conv_cfg_if.sv
// Layer configuration link; fields hold from start_whole until done_all and weight_ack answers weight_req once
`default_nettype none

interface conv_cfg_if;
    import conv_ctrl_pkg::*;

    // Layer launch and configuration
    logic    start_whole;
    stride_t stride;
    pad_t    padding;
    ksize_t  kernel_size;
    count_t  input_channels;
    count_t  filter_number;
    count_t  temporal_length;

    // Per-filter weight handshake and progress
    logic    weight_req;
    logic    weight_ack;
    logic    done_filter;
    logic    done_all;

    modport sched (
        output start_whole, stride, padding, kernel_size,
        output input_channels, filter_number, temporal_length, weight_ack,
        input  weight_req, done_all
    );

    modport ctrl (
        input  start_whole, stride, padding, kernel_size,
        input  input_channels, filter_number, temporal_length, weight_ack,
        output weight_req, done_filter, done_all
    );

endinterface

`default_nettype wire

//--- logic/layer_sequencer.sv
// Runs layers 0 to NUM_LAYERS-1 once per reset; data strobes arriving before layer_complete count for the running layer
`default_nettype none

module layer_sequencer #(
    parameter int NUM_LAYERS = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     global_start,
    input  logic                     weight_write_done,
    input  logic                     ifmap_write_done,
    input  logic                     layer_complete,
    output logic                     start,
    output conv_ctrl_pkg::layer_id_t layer_id,
    output logic                     global_done,
    output logic                     layer_transition,
    output logic                     clear_output_bram,
    output logic                     data_ready
);
    import conv_ctrl_pkg::*;

    seq_state_t state;
    logic       weight_seen;
    logic       ifmap_seen;
    logic       last_layer;

    assign data_ready = weight_seen & ifmap_seen;
    assign last_layer = (layer_id == layer_id_t'(NUM_LAYERS - 1));

    // Data arrival flags, also latched before global_start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_seen <= 1'b0;
            ifmap_seen  <= 1'b0;
        end else if (layer_complete) begin
            // Fresh flags for the next layer
            weight_seen <= weight_write_done;
            ifmap_seen  <= ifmap_write_done;
        end else begin
            weight_seen <= weight_seen | weight_write_done;
            ifmap_seen  <= ifmap_seen | ifmap_write_done;
        end
    end

    // ========================================
    // Layer sequencing FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= SEQ_IDLE;
            layer_id          <= '0;
            start             <= 1'b0;
            global_done       <= 1'b0;
            layer_transition  <= 1'b0;
            clear_output_bram <= 1'b0;
        end else begin
            // Pulses by default
            start             <= 1'b0;
            layer_transition  <= 1'b0;
            clear_output_bram <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (global_start) begin
                        state <= SEQ_WAIT_DATA;
                    end
                end
                SEQ_WAIT_DATA: begin
                    if (data_ready) begin
                        start <= 1'b1;
                        state <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (layer_complete) begin
                        layer_transition  <= 1'b1;
                        clear_output_bram <= 1'b1;
                        state             <= SEQ_NEXT;
                    end
                end
                SEQ_NEXT: begin
                    if (last_layer) begin
                        global_done <= 1'b1;
                        state       <= SEQ_FINISHED;
                    end else begin
                        layer_id <= layer_id + 1'b1;
                        state    <= SEQ_WAIT_DATA;
                    end
                end
                // Held until reset
                SEQ_FINISHED: state <= SEQ_FINISHED;
                default:      state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/layer_scheduler.sv
// Eight fixed layer configurations indexed by the low three bits of layer_id; read_done is expected after done_all
`default_nettype none

module layer_scheduler (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  conv_ctrl_pkg::layer_id_t layer_id,
    input  logic                     read_done,
    input  logic                     transmission_active,
    output logic                     layer_complete,
    conv_cfg_if.sched                cfg
);
    import conv_ctrl_pkg::*;

    // ========================================
    // Configuration ROM, one column per field
    // ========================================
    localparam stride_t ROM_STRIDE [ROM_DEPTH] = '{2'd1, 2'd2, 2'd1, 2'd3, 2'd1, 2'd2, 2'd1, 2'd3};
    localparam pad_t    ROM_PAD    [ROM_DEPTH] = '{3'd1, 3'd2, 3'd0, 3'd3, 3'd0, 3'd1, 3'd2, 3'd0};
    localparam ksize_t  ROM_KSIZE  [ROM_DEPTH] = '{4'd3, 4'd5, 4'd4, 4'd7, 4'd1, 4'd3, 4'd5, 4'd2};
    localparam count_t  ROM_CHAN   [ROM_DEPTH] = '{8'd2, 8'd3, 8'd1, 8'd2, 8'd4, 8'd2, 8'd1, 8'd3};
    localparam count_t  ROM_FILT   [ROM_DEPTH] = '{8'd2, 8'd2, 8'd3, 8'd1, 8'd2, 8'd4, 8'd2, 8'd2};
    localparam count_t  ROM_TLEN   [ROM_DEPTH] = '{8'd8, 8'd10, 8'd6, 8'd9, 8'd5, 8'd7, 8'd4, 8'd8};

    sched_state_t state;
    logic [2:0]   rom_idx;
    logic         done_all_q;
    logic         done_all_rise;

    assign rom_idx       = layer_id[2:0];
    assign done_all_rise = cfg.done_all & ~done_all_q;

    // Fields loaded on start, held for the whole layer
    always_ff @(posedge clk) begin
        if (state == SCH_IDLE && start) begin
            cfg.stride          <= ROM_STRIDE[rom_idx];
            cfg.padding         <= ROM_PAD[rom_idx];
            cfg.kernel_size     <= ROM_KSIZE[rom_idx];
            cfg.input_channels  <= ROM_CHAN[rom_idx];
            cfg.filter_number   <= ROM_FILT[rom_idx];
            cfg.temporal_length <= ROM_TLEN[rom_idx];
        end
    end

    // ========================================
    // Layer FSM and weight acknowledge
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= SCH_IDLE;
            cfg.start_whole <= 1'b0;
            cfg.weight_ack  <= 1'b0;
            layer_complete  <= 1'b0;
            done_all_q      <= 1'b0;
        end else begin
            cfg.start_whole <= 1'b0;
            layer_complete  <= 1'b0;
            done_all_q      <= cfg.done_all;
            // One ack per request, held off while output is being sent
            cfg.weight_ack  <= (state == SCH_RUN) && cfg.weight_req
                               && !transmission_active && !cfg.weight_ack;
            case (state)
                SCH_IDLE: begin
                    if (start) begin
                        cfg.start_whole <= 1'b1;
                        state           <= SCH_START;
                    end
                end
                // start_whole is high in this cycle
                SCH_START: state <= SCH_RUN;
                SCH_RUN: begin
                    if (done_all_rise) begin
                        state <= SCH_WAIT_READ;
                    end
                end
                SCH_WAIT_READ: begin
                    if (read_done) begin
                        layer_complete <= 1'b1;
                        state          <= SCH_COMPLETE;
                    end
                end
                SCH_COMPLETE: state <= SCH_IDLE;
                default:      state <= SCH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/conv_addr_ctrl.sv
// Address walk for one layer; the configuration must give at least one output and all addresses must fit ADDR_W
`default_nettype none

module conv_addr_ctrl #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              out_new_val_sign,
    conv_cfg_if.ctrl          cfg,
    output logic [ADDR_W-1:0] in_addr,
    output logic [ADDR_W-1:0] w_addr,
    output logic [ADDR_W-1:0] out_addr,
    output logic              in_rd_en,
    output logic              w_rd_en,
    output logic              pad,
    output logic              out_wr_en
);
    import conv_ctrl_pkg::*;

    addr_state_t              state;
    count_t                   f_cnt;
    count_t                   o_cnt;
    count_t                   c_cnt;
    ksize_t                   k_cnt;
    count_t                   out_len;
    logic [8:0]               span;
    // Input index of tap 0, o*stride - padding
    logic signed [ADDR_W:0]   pos_base;
    logic signed [ADDR_W:0]   idx;
    logic [ADDR_W-1:0]        in_ch_base;
    logic [ADDR_W-1:0]        w_ch_base;
    logic [ADDR_W-1:0]        w_f_base;
    logic [ADDR_W-1:0]        out_base;
    logic                     in_range;
    logic                     tap;
    logic                     last_k;
    logic                     last_c;
    logic                     last_o;
    logic                     last_f;

    assign span   = 9'(cfg.temporal_length) + 9'({cfg.padding, 1'b0}) - 9'(cfg.kernel_size);
    assign last_k = (k_cnt == ksize_t'(cfg.kernel_size - 1'b1));
    assign last_c = (c_cnt == count_t'(cfg.input_channels - 1'b1));
    assign last_o = (o_cnt == count_t'(out_len - 1'b1));
    assign last_f = (f_cnt == count_t'(cfg.filter_number - 1'b1));

    // ========================================
    // Tap and write decode
    // ========================================
    assign idx      = pos_base + $signed((ADDR_W + 1)'(k_cnt));
    assign in_range = !idx[ADDR_W] && (idx < $signed((ADDR_W + 1)'(cfg.temporal_length)));
    assign tap      = (state == ADR_TAP);

    assign in_rd_en  = tap & in_range;
    assign pad       = tap & ~in_range;
    assign w_rd_en   = tap;
    assign in_addr   = in_ch_base + idx[ADDR_W-1:0];
    assign w_addr    = w_ch_base + ADDR_W'(k_cnt);
    assign out_addr  = out_base + ADDR_W'(o_cnt);
    // Write lands in the cycle the array flags a result
    assign out_wr_en = (state == ADR_WAIT_RESULT) & out_new_val_sign;

    assign cfg.weight_req  = (state == ADR_WEIGHT_REQ);
    assign cfg.done_filter = (state == ADR_NEXT_FILTER);
    assign cfg.done_all    = (state == ADR_DONE);

    // ========================================
    // Loop counters and running bases
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ADR_IDLE;
            f_cnt      <= '0;
            o_cnt      <= '0;
            c_cnt      <= '0;
            k_cnt      <= '0;
            out_len    <= '0;
            pos_base   <= '0;
            in_ch_base <= '0;
            w_ch_base  <= '0;
            w_f_base   <= '0;
            out_base   <= '0;
        end else begin
            case (state)
                ADR_IDLE, ADR_DONE: begin
                    if (cfg.start_whole) begin
                        f_cnt      <= '0;
                        o_cnt      <= '0;
                        c_cnt      <= '0;
                        k_cnt      <= '0;
                        pos_base   <= -$signed((ADDR_W + 1)'(cfg.padding));
                        in_ch_base <= '0;
                        w_ch_base  <= '0;
                        w_f_base   <= '0;
                        out_base   <= '0;
                        // Stride is 1 to 3, so the divide is a small case
                        case (cfg.stride)
                            2'd2:    out_len <= count_t'(span >> 1) + 8'd1;
                            2'd3:    out_len <= count_t'(span / 9'd3) + 8'd1;
                            default: out_len <= count_t'(span) + 8'd1;
                        endcase
                        state <= ADR_WEIGHT_REQ;
                    end
                end
                ADR_WEIGHT_REQ: begin
                    if (cfg.weight_ack) begin
                        state <= ADR_TAP;
                    end
                end
                ADR_TAP: begin
                    if (!last_k) begin
                        k_cnt <= k_cnt + 1'b1;
                    end else begin
                        k_cnt <= '0;
                        if (last_c) begin
                            state <= ADR_WAIT_RESULT;
                        end else begin
                            c_cnt      <= c_cnt + 1'b1;
                            in_ch_base <= in_ch_base + ADDR_W'(cfg.temporal_length);
                            w_ch_base  <= w_ch_base + ADDR_W'(cfg.kernel_size);
                        end
                    end
                end
                ADR_WAIT_RESULT: begin
                    if (out_new_val_sign) begin
                        state <= ADR_WRITE;
                    end
                end
                ADR_WRITE: begin
                    c_cnt      <= '0;
                    in_ch_base <= '0;
                    if (last_o) begin
                        // Next filter's weights follow the last channel
                        w_ch_base <= w_ch_base + ADDR_W'(cfg.kernel_size);
                        w_f_base  <= w_ch_base + ADDR_W'(cfg.kernel_size);
                        state     <= ADR_NEXT_FILTER;
                    end else begin
                        w_ch_base <= w_f_base;
                        o_cnt     <= o_cnt + 1'b1;
                        pos_base  <= pos_base + $signed((ADDR_W + 1)'(cfg.stride));
                        state     <= ADR_TAP;
                    end
                end
                ADR_NEXT_FILTER: begin
                    o_cnt    <= '0;
                    pos_base <= -$signed((ADDR_W + 1)'(cfg.padding));
                    out_base <= out_base + ADDR_W'(out_len);
                    if (last_f) begin
                        state <= ADR_DONE;
                    end else begin
                        f_cnt <= f_cnt + 1'b1;
                        state <= ADR_WEIGHT_REQ;
                    end
                end
                default: state <= ADR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/conv_ctrl_top.sv
// Control top without datapath; NUM_LAYERS must be 1 to 8 and addresses wrap beyond ADDR_W bits
`default_nettype none

module conv_ctrl_top #(
    parameter int ADDR_W     = 10,
    parameter int NUM_LAYERS = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     global_start,
    input  logic                     weight_write_done,
    input  logic                     ifmap_write_done,
    input  logic                     read_done,
    input  logic                     transmission_active,
    input  logic                     out_new_val_sign,
    output logic [ADDR_W-1:0]        in_addr,
    output logic [ADDR_W-1:0]        w_addr,
    output logic [ADDR_W-1:0]        out_addr,
    output logic                     in_rd_en,
    output logic                     w_rd_en,
    output logic                     pad,
    output logic                     out_wr_en,
    output conv_ctrl_pkg::layer_id_t current_layer_id,
    output logic                     global_done,
    output logic                     layer_transition,
    output logic                     clear_output_bram,
    output logic                     data_ready,
    output logic                     done_filter
);

    // Sequencer to scheduler
    logic seq_start;
    logic layer_complete;

    conv_cfg_if cfg_bus ();

    assign done_filter = cfg_bus.done_filter;

    // ========================================
    // Layer order and data tracking
    // ========================================
    layer_sequencer #(
        .NUM_LAYERS (NUM_LAYERS)
    ) u_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .global_start      (global_start),
        .weight_write_done (weight_write_done),
        .ifmap_write_done  (ifmap_write_done),
        .layer_complete    (layer_complete),
        .start             (seq_start),
        .layer_id          (current_layer_id),
        .global_done       (global_done),
        .layer_transition  (layer_transition),
        .clear_output_bram (clear_output_bram),
        .data_ready        (data_ready)
    );

    // Configuration and read-back wait
    layer_scheduler u_scheduler (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (seq_start),
        .layer_id            (current_layer_id),
        .read_done           (read_done),
        .transmission_active (transmission_active),
        .layer_complete      (layer_complete),
        .cfg                 (cfg_bus.sched)
    );

    // Buffer address generation
    conv_addr_ctrl #(
        .ADDR_W (ADDR_W)
    ) u_addr_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .out_new_val_sign (out_new_val_sign),
        .cfg              (cfg_bus.ctrl),
        .in_addr          (in_addr),
        .w_addr           (w_addr),
        .out_addr         (out_addr),
        .in_rd_en         (in_rd_en),
        .w_rd_en          (w_rd_en),
        .pad              (pad),
        .out_wr_en        (out_wr_en)
    );

endmodule

`default_nettype wire

//--- bench/conv_ctrl_tb.sv
// Runs the four ROM layers from reset once; expected counts come from the stim file, run from project root
`default_nettype none

module conv_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W        = 10;
    localparam int NUM_LAYERS    = 4;
    localparam int FIELDS        = 9;
    localparam int LAYER_TIMEOUT = 5000;
    localparam int WAIT_TIMEOUT  = 200;

    // ROM entries of layers 0 to 3
    localparam int CFG_STRIDE [NUM_LAYERS] = '{1, 2, 1, 3};
    localparam int CFG_PAD    [NUM_LAYERS] = '{1, 2, 0, 3};
    localparam int CFG_KSIZE  [NUM_LAYERS] = '{3, 5, 4, 7};
    localparam int CFG_CHAN   [NUM_LAYERS] = '{2, 3, 1, 2};
    localparam int CFG_TLEN   [NUM_LAYERS] = '{8, 10, 6, 9};

    logic clk;
    logic rst_n;
    logic global_start;
    logic weight_write_done;
    logic ifmap_write_done;
    logic read_done;
    logic transmission_active;
    logic out_new_val_sign;
    logic [ADDR_W-1:0] in_addr;
    logic [ADDR_W-1:0] w_addr;
    logic [ADDR_W-1:0] out_addr;
    logic in_rd_en;
    logic w_rd_en;
    logic pad;
    logic out_wr_en;
    conv_ctrl_pkg::layer_id_t current_layer_id;
    logic global_done;
    logic layer_transition;
    logic clear_output_bram;
    logic data_ready;
    logic done_filter;

    logic [15:0] stim [0:NUM_LAYERS*FIELDS-1];

    // Stimulus side state
    logic launched;
    int   reads_given;
    int   tx_left;

    // Running totals kept by the monitor
    int   in_total    = 0;
    int   pad_total   = 0;
    int   wr_total    = 0;
    int   sum_total   = 0;
    int   df_total    = 0;
    int   trans_total = 0;
    int   clear_total = 0;
    int   prev_id     = 0;
    logic gd_seen     = 1'b0;
    logic tap_pending = 1'b1;
    logic tx_d1       = 1'b0;
    logic tx_d2       = 1'b0;

    // Reference loop position of the next tap
    int   act_layer   = 0;
    int   exp_f       = 0;
    int   exp_o       = 0;
    int   exp_c       = 0;
    int   exp_k       = 0;

    conv_ctrl_top #(
        .ADDR_W     (ADDR_W),
        .NUM_LAYERS (NUM_LAYERS)
    ) UUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .global_start        (global_start),
        .weight_write_done   (weight_write_done),
        .ifmap_write_done    (ifmap_write_done),
        .read_done           (read_done),
        .transmission_active (transmission_active),
        .out_new_val_sign    (out_new_val_sign),
        .in_addr             (in_addr),
        .w_addr              (w_addr),
        .out_addr            (out_addr),
        .in_rd_en            (in_rd_en),
        .w_rd_en             (w_rd_en),
        .pad                 (pad),
        .out_wr_en           (out_wr_en),
        .current_layer_id    (current_layer_id),
        .global_done         (global_done),
        .layer_transition    (layer_transition),
        .clear_output_bram   (clear_output_bram),
        .data_ready          (data_ready),
        .done_filter         (done_filter)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Array result flag, random about two cycles in three
    initial begin : result_flag_gen
        void'($urandom(79));
        out_new_val_sign = 1'b0;
        forever begin
            @(posedge clk);
            out_new_val_sign <= (($urandom % 3) != 0);
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected)
        else report_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    // One clock; also plays out the transmission burst
    task automatic next_cycle();
        @(posedge clk);
        transmission_active <= (tx_left != 0);
        if (tx_left != 0) begin
            tx_left = tx_left - 1;
        end
    endtask

    // Tap addresses from the convolution rule, then step k, c and o
    task automatic compare_tap();
        int i;
        int c_len;
        int k_len;
        c_len = CFG_CHAN[act_layer];
        k_len = CFG_KSIZE[act_layer];
        i     = exp_o * CFG_STRIDE[act_layer] + exp_k - CFG_PAD[act_layer];
        if (i < 0 || i >= CFG_TLEN[act_layer]) begin
            check_value("pad", int'(pad), 1);
        end else begin
            check_value("in_rd_en", int'(in_rd_en), 1);
            check_value("in_addr", int'(in_addr), exp_c * CFG_TLEN[act_layer] + i);
        end
        check_value("w_addr", int'(w_addr), (exp_f * c_len + exp_c) * k_len + exp_k);
        exp_k = exp_k + 1;
        if (exp_k == k_len) begin
            exp_k = 0;
            exp_c = exp_c + 1;
            if (exp_c == c_len) begin
                exp_c = 0;
                exp_o = exp_o + 1;
            end
        end
    endtask

    // ========================================
    // Monitor, samples on the falling edge
    // ========================================
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(in_rd_en && pad))
            else report_failure("pad and in_rd_en are high in the same cycle");
            assert (!out_wr_en || out_new_val_sign)
            else report_failure("out_wr_en is high while out_new_val_sign is low");
            assert (launched || !(in_rd_en || w_rd_en || pad || out_wr_en || done_filter))
            else report_failure("read or write strobe while no layer is running");

            // First tap of a filter needs an ack given while transmission was idle
            if (w_rd_en && tap_pending) begin
                assert (!tx_d2)
                else report_failure("first tap began while transmission_active held off the ack");
                tap_pending = 1'b0;
            end
            if (w_rd_en) begin
                compare_tap();
            end
            if (done_filter) begin
                tap_pending = 1'b1;
                df_total    = df_total + 1;
                exp_f       = exp_f + 1;
                exp_o       = 0;
            end

            if (in_rd_en)  in_total  = in_total + 1;
            if (pad)       pad_total = pad_total + 1;
            if (out_wr_en) begin
                wr_total  = wr_total + 1;
                sum_total = sum_total + int'(out_addr);
            end
            if (clear_output_bram) begin
                // Only after this layer's read_done
                check_value("read_done count at clear_output_bram", reads_given,
                            clear_total + 1);
                clear_total = clear_total + 1;
            end
            if (layer_transition) begin
                // Only after this layer's read_done
                check_value("read_done count at layer_transition", reads_given, trans_total + 1);
                trans_total = trans_total + 1;
            end

            if (int'(current_layer_id) != prev_id) begin
                check_value("current_layer_id", int'(current_layer_id), prev_id + 1);
                prev_id = int'(current_layer_id);
            end

            if (gd_seen) begin
                check_value("global_done", int'(global_done), 1);
            end else if (global_done) begin
                check_value("layer_transition count at global_done", trans_total, NUM_LAYERS);
                gd_seen = 1'b1;
            end

            tx_d2 = tx_d1;
            tx_d1 = transmission_active;
        end
    end

    // ========================================
    // One layer from data strobes to transition
    // ========================================
    task automatic run_layer(input int layer);
        int base;
        int w_dly;
        int i_dly;
        int rd_dly;
        int last;
        int cyc;
        int cnt;
        int in0;
        int pad0;
        int wr0;
        int sum0;
        int df0;
        int tr0;
        int cl0;
        base   = layer * FIELDS;
        w_dly  = int'(stim[base]);
        i_dly  = int'(stim[base+1]);
        rd_dly = int'(stim[base+3]);
        @(negedge clk);
        check_value("current_layer_id", int'(current_layer_id), layer);
        act_layer = layer;
        exp_f     = 0;
        exp_o     = 0;
        exp_c     = 0;
        exp_k     = 0;
        in0  = in_total;
        pad0 = pad_total;
        wr0  = wr_total;
        sum0 = sum_total;
        df0  = df_total;
        tr0  = trans_total;
        cl0  = clear_total;

        // Data strobes at their own delays
        last = (w_dly > i_dly) ? w_dly : i_dly;
        for (cyc = 0; cyc <= last; cyc++) begin
            next_cycle();
            weight_write_done <= (cyc == w_dly);
            ifmap_write_done  <= (cyc == i_dly);
            if (layer == 0 && cyc == w_dly) begin
                // ifmap alone is not enough
                @(negedge clk);
                check_value("data_ready", int'(data_ready), 0);
            end
        end
        next_cycle();
        weight_write_done <= 1'b0;
        ifmap_write_done  <= 1'b0;

        if (layer == 0) begin
            // Data in place but no global_start yet
            repeat (4) next_cycle();
            @(negedge clk);
            check_value("data_ready", int'(data_ready), 1);
            next_cycle();
            global_start <= 1'b1;
            next_cycle();
            global_start <= 1'b0;
        end
        launched = 1'b1;
        tx_left  = int'(stim[base+2]);

        cnt = 0;
        while (df_total - df0 < int'(stim[base+8])) begin
            next_cycle();
            cnt = cnt + 1;
            if (cnt > LAYER_TIMEOUT) begin
                report_failure($sformatf("Timeout waiting for the filters of layer %0d", layer));
            end
        end
        launched = 1'b0;

        // Read-back of the output buffer
        repeat (rd_dly + 1) next_cycle();
        next_cycle();
        read_done   <= 1'b1;
        reads_given = reads_given + 1;
        next_cycle();
        read_done <= 1'b0;

        cnt = 0;
        while (trans_total == tr0) begin
            next_cycle();
            cnt = cnt + 1;
            if (cnt > WAIT_TIMEOUT) begin
                report_failure($sformatf("Timeout waiting for layer_transition of layer %0d", layer));
            end
        end
        // Layer id settles one cycle after the pulse
        repeat (2) next_cycle();

        check_value("in_rd_en count", in_total - in0, int'(stim[base+4]));
        check_value("pad count", pad_total - pad0, int'(stim[base+5]));
        check_value("out_wr_en count", wr_total - wr0, int'(stim[base+6]));
        check_value("out_addr sum", sum_total - sum0, int'(stim[base+7]));
        check_value("done_filter count", df_total - df0, int'(stim[base+8]));
        check_value("layer_transition count", trans_total - tr0, 1);
        check_value("clear_output_bram count", clear_total - cl0, 1);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin : stimulus
        int layer;
        int cnt;
        rst_n               = 1'b0;
        global_start        = 1'b0;
        weight_write_done   = 1'b0;
        ifmap_write_done    = 1'b0;
        read_done           = 1'b0;
        transmission_active = 1'b0;
        launched            = 1'b0;
        reads_given         = 0;
        tx_left             = 0;
        $readmemh("bench/conv_ctrl_stim.txt", stim);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        @(negedge clk);
        check_value("global_done", int'(global_done), 0);
        check_value("layer_transition", int'(layer_transition), 0);
        check_value("clear_output_bram", int'(clear_output_bram), 0);
        check_value("data_ready", int'(data_ready), 0);
        check_value("done_filter", int'(done_filter), 0);
        check_value("out_wr_en", int'(out_wr_en), 0);
        check_value("w_rd_en", int'(w_rd_en), 0);
        check_value("current_layer_id", int'(current_layer_id), 0);

        for (layer = 0; layer < NUM_LAYERS; layer++) begin
            run_layer(layer);
        end

        cnt = 0;
        @(negedge clk);
        while (!global_done) begin
            next_cycle();
            @(negedge clk);
            cnt = cnt + 1;
            if (cnt > WAIT_TIMEOUT) begin
                report_failure("Timeout waiting for global_done after the last layer");
            end
        end

        // Quiet tail, the monitor flags any late strobe
        repeat (20) next_cycle();
        @(negedge clk);
        check_value("global_done", int'(global_done), 1);
        check_value("current_layer_id", int'(current_layer_id), NUM_LAYERS - 1);
        check_value("layer_transition total", trans_total, NUM_LAYERS);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/conv_ctrl_pkg.sv
logic/conv_cfg_if.sv
logic/layer_sequencer.sv
logic/layer_scheduler.sv
logic/conv_addr_ctrl.sv
logic/conv_ctrl_top.sv
bench/conv_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the convolution control testbench

VERILATOR ?= verilator
TOP       ?= conv_ctrl_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/conv_ctrl_stim.txt
// Per layer: weight strobe delay, ifmap strobe delay, transmission_active cycles, read_done delay,
// then expected in_rd_en count, pad count, out_wr_en count, out_addr sum, done_filter pulses (hex)
//
// Layer 0: stride 1, pad 1, k 3, 2 channels, 2 filters, length 8, out_len 8
// ifmap strobe comes before the weight strobe here
06 02 00 05 58 08 10 78 02
//
// Layer 1: stride 2, pad 2, k 5, 3 channels, 2 filters, length 10, out_len 5
// Long transmission burst over the first weight request
03 04 0E 09 84 12 0A 2D 02
//
// Layer 2: stride 1, pad 0, k 4, 1 channel, 3 filters, length 6, out_len 3
// Both strobes in the same cycle, no padding taps
02 02 03 01 24 00 09 24 03
//
// Layer 3: stride 3, pad 3, k 7, 2 channels, 1 filter, length 9, out_len 3
// Slow read-back after the last write
05 01 14 0C 22 08 03 03 01
